// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int dmem_words = 64;

    // addi x0, x0, 0
    localparam logic [31:0] nop_inst = 32'h0000_0013;

    // Major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    // funct3 values
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_word = 3'b010;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;

    // funct7 of sub
    localparam logic [6:0] f7_alt = 7'b0100000;

    // ALU operations passed from decode to execute
    localparam logic [3:0] alu_add = 4'd0;
    localparam logic [3:0] alu_sub = 4'd1;
    localparam logic [3:0] alu_and = 4'd2;
    localparam logic [3:0] alu_or  = 4'd3;
    localparam logic [3:0] alu_xor = 4'd4;
    localparam logic [3:0] alu_slt = 4'd5;
    localparam logic [3:0] alu_sll = 4'd6;
    localparam logic [3:0] alu_srl = 4'd7;

    // One instruction word seen through the R, I and S/B layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
    } instr_u;

endpackage

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     stall,
    input  logic                     redirect,
    input  logic [cpu_pkg::xlen-1:0] redirect_pc,
    input  logic [cpu_pkg::xlen-1:0] imem_data,
    output logic [cpu_pkg::xlen-1:0] imem_addr,
    output logic [cpu_pkg::xlen-1:0] if_pc,
    output cpu_pkg::instr_u          if_inst
);
    import cpu_pkg::*;

    logic [xlen-1:0] pc;

    assign imem_addr = pc;

    // Redirect wins over stall, the squashed slot becomes a NOP
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= '0;
            if_pc   <= '0;
            if_inst <= nop_inst;
        end else if (redirect) begin
            pc      <= redirect_pc;
            if_inst <= nop_inst;
        end else if (!stall) begin
            pc      <= pc + 32'd4;
            if_pc   <= pc;
            if_inst <= imem_data;
        end
    end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs1,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs2,
    input  logic [cpu_pkg::reg_addr_w-1:0] rd,
    input  logic                           wr_en,
    input  logic [cpu_pkg::xlen-1:0]       wr_data,
    output logic [cpu_pkg::xlen-1:0]       rs1_data,
    output logic [cpu_pkg::xlen-1:0]       rs2_data
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    // x0 is cleared at reset and never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd != '0) begin
            regs[rd] <= wr_data;
        end
    end

    // Same-cycle write is visible to decode
    assign rs1_data = (rs1 == '0) ? '0 : (wr_en && rd == rs1) ? wr_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (wr_en && rd == rs2) ? wr_data : regs[rs2];

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::xlen-1:0]       if_pc,
    input  cpu_pkg::instr_u                if_inst,
    input  logic [cpu_pkg::xlen-1:0]       rs1_data,
    input  logic [cpu_pkg::xlen-1:0]       rs2_data,
    input  logic                           redirect,
    output logic [cpu_pkg::reg_addr_w-1:0] rs1,
    output logic [cpu_pkg::reg_addr_w-1:0] rs2,
    output logic                           stall,
    output logic [3:0]                     ex_alu_op,
    output logic                           ex_use_imm,
    output logic                           ex_mem_read,
    output logic                           ex_mem_write,
    output logic                           ex_branch,
    output logic                           ex_branch_ne,
    output logic                           ex_reg_write,
    output logic [cpu_pkg::xlen-1:0]       ex_pc,
    output logic [cpu_pkg::xlen-1:0]       ex_imm,
    output logic [cpu_pkg::reg_addr_w-1:0] ex_rs1,
    output logic [cpu_pkg::reg_addr_w-1:0] ex_rs2,
    output logic [cpu_pkg::xlen-1:0]       ex_rs1_data,
    output logic [cpu_pkg::xlen-1:0]       ex_rs2_data,
    output logic [cpu_pkg::reg_addr_w-1:0] ex_rd
);
    import cpu_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm;
    logic [3:0]      alu_op;
    logic            use_imm, use_rs1, use_rs2;
    logic            mem_read, mem_write, branch, reg_write;
    logic            kill;

    assign opcode = if_inst.r_fmt.opcode;
    assign funct3 = if_inst.r_fmt.funct3;
    assign rs1    = if_inst.r_fmt.rs1;
    assign rs2    = if_inst.s_fmt.rs2;

    assign imm_i = {{20{if_inst.i_fmt.imm[11]}}, if_inst.i_fmt.imm};
    assign imm_s = {{20{if_inst.s_fmt.imm_hi[6]}}, if_inst.s_fmt.imm_hi, if_inst.s_fmt.imm_lo};
    // B-type bits are scattered over the S-type fields
    assign imm_b = {{20{if_inst.s_fmt.imm_hi[6]}}, if_inst.s_fmt.imm_lo[0],
                    if_inst.s_fmt.imm_hi[5:0], if_inst.s_fmt.imm_lo[4:1], 1'b0};

    always_comb begin
        alu_op    = alu_add;
        imm       = imm_i;
        use_imm   = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        reg_write = 1'b0;
        case (opcode)
            op_reg: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                reg_write = 1'b1;
                case (funct3)
                    f3_add:  alu_op = (if_inst.r_fmt.funct7 == f7_alt) ? alu_sub : alu_add;
                    f3_sll:  alu_op = alu_sll;
                    f3_slt:  alu_op = alu_slt;
                    f3_xor:  alu_op = alu_xor;
                    f3_srl:  alu_op = alu_srl;
                    f3_or:   alu_op = alu_or;
                    f3_and:  alu_op = alu_and;
                    default: reg_write = 1'b0;
                endcase
            end
            op_imm: begin
                use_imm   = 1'b1;
                use_rs1   = 1'b1;
                reg_write = 1'b1;
                case (funct3)
                    f3_add:  alu_op = alu_add;
                    f3_slt:  alu_op = alu_slt;
                    f3_xor:  alu_op = alu_xor;
                    f3_or:   alu_op = alu_or;
                    f3_and:  alu_op = alu_and;
                    default: reg_write = 1'b0;
                endcase
            end
            op_load: begin
                use_imm   = 1'b1;
                use_rs1   = (funct3 == f3_word);
                mem_read  = (funct3 == f3_word);
                reg_write = (funct3 == f3_word);
            end
            op_store: begin
                imm       = imm_s;
                use_imm   = 1'b1;
                use_rs1   = (funct3 == f3_word);
                use_rs2   = (funct3 == f3_word);
                mem_write = (funct3 == f3_word);
            end
            op_branch: begin
                imm     = imm_b;
                branch  = (funct3 == f3_beq) || (funct3 == f3_bne);
                use_rs1 = branch;
                use_rs2 = branch;
            end
            default: ;
        endcase
    end

    // Load in execute feeding this instruction
    assign stall = ex_mem_read && ex_rd != '0 &&
                   ((use_rs1 && ex_rd == rs1) || (use_rs2 && ex_rd == rs2));

    assign kill = redirect || stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_branch    <= 1'b0;
            ex_reg_write <= 1'b0;
        end else begin
            ex_mem_read  <= mem_read && !kill;
            ex_mem_write <= mem_write && !kill;
            ex_branch    <= branch && !kill;
            ex_reg_write <= reg_write && !kill;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op    <= alu_op;
        ex_use_imm   <= use_imm;
        ex_branch_ne <= (funct3 == f3_bne);
        ex_pc        <= if_pc;
        ex_imm       <= imm;
        ex_rs1       <= rs1;
        ex_rs2       <= rs2;
        ex_rs1_data  <= rs1_data;
        ex_rs2_data  <= rs2_data;
        ex_rd        <= if_inst.i_fmt.rd;
    end

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [3:0]                     ex_alu_op,
    input  logic                           ex_use_imm,
    input  logic                           ex_mem_read,
    input  logic                           ex_mem_write,
    input  logic                           ex_branch,
    input  logic                           ex_branch_ne,
    input  logic                           ex_reg_write,
    input  logic [cpu_pkg::xlen-1:0]       ex_pc,
    input  logic [cpu_pkg::xlen-1:0]       ex_imm,
    input  logic [cpu_pkg::reg_addr_w-1:0] ex_rs1,
    input  logic [cpu_pkg::reg_addr_w-1:0] ex_rs2,
    input  logic [cpu_pkg::xlen-1:0]       ex_rs1_data,
    input  logic [cpu_pkg::xlen-1:0]       ex_rs2_data,
    input  logic [cpu_pkg::reg_addr_w-1:0] ex_rd,
    input  logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
    input  logic                           wb_reg_write,
    input  logic [cpu_pkg::xlen-1:0]       wb_data,
    output logic                           redirect,
    output logic [cpu_pkg::xlen-1:0]       redirect_pc,
    output logic [cpu_pkg::xlen-1:0]       mem_alu_result,
    output logic [cpu_pkg::xlen-1:0]       mem_store_data,
    output logic [cpu_pkg::reg_addr_w-1:0] mem_rd,
    output logic                           mem_mem_read,
    output logic                           mem_mem_write,
    output logic                           mem_reg_write
);
    import cpu_pkg::*;

    logic [xlen-1:0] op_a, rs2_val, op_b, alu_result;

    // Memory stage first, then writeback; loads in memory never forward
    function automatic logic [xlen-1:0] fwd(input logic [reg_addr_w-1:0] idx,
                                            input logic [xlen-1:0]       reg_val);
        if (idx != '0 && mem_reg_write && !mem_mem_read && mem_rd == idx) begin
            return mem_alu_result;
        end
        if (idx != '0 && wb_reg_write && wb_rd == idx) begin
            return wb_data;
        end
        return reg_val;
    endfunction

    always_comb begin
        op_a    = fwd(ex_rs1, ex_rs1_data);
        rs2_val = fwd(ex_rs2, ex_rs2_data);
    end

    assign op_b = ex_use_imm ? ex_imm : rs2_val;

    always_comb begin
        case (ex_alu_op)
            alu_sub: alu_result = op_a - op_b;
            alu_and: alu_result = op_a & op_b;
            alu_or:  alu_result = op_a | op_b;
            alu_xor: alu_result = op_a ^ op_b;
            alu_slt: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_sll: alu_result = op_a << op_b[4:0];
            alu_srl: alu_result = op_a >> op_b[4:0];
            default: alu_result = op_a + op_b;
        endcase
    end

    // beq takes on equal operands, bne on unequal
    assign redirect    = ex_branch && ((op_a == rs2_val) != ex_branch_ne);
    assign redirect_pc = ex_pc + ex_imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_rd        <= '0;
        end else begin
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
            mem_reg_write <= ex_reg_write && !ex_branch;
            mem_rd        <= ex_rd;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_result <= alu_result;
        mem_store_data <= rs2_val;
    end

endmodule

// ==== rtl/result_stage.sv ====
`timescale 1ns/1ps

module result_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::xlen-1:0]       mem_alu_result,
    input  logic [cpu_pkg::xlen-1:0]       mem_store_data,
    input  logic [cpu_pkg::reg_addr_w-1:0] mem_rd,
    input  logic                           mem_mem_read,
    input  logic                           mem_mem_write,
    input  logic                           mem_reg_write,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
    output logic                           wb_reg_write,
    output logic [cpu_pkg::xlen-1:0]       wb_data
);
    import cpu_pkg::*;

    logic [xlen-1:0]               dmem [dmem_words];
    logic [$clog2(dmem_words)-1:0] word_idx;
    logic [xlen-1:0]               load_data;

    // Word address, low two bits ignored
    assign word_idx = mem_alu_result[$clog2(dmem_words)+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_words; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_mem_write) begin
            dmem[word_idx] <= mem_store_data;
        end
    end

    assign load_data = dmem[word_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_reg_write <= 1'b0;
            wb_rd        <= '0;
        end else begin
            wb_reg_write <= mem_reg_write;
            wb_rd        <= mem_rd;
        end
    end

    always_ff @(posedge clk) begin
        wb_data <= mem_mem_read ? load_data : mem_alu_result;
    end

endmodule

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::xlen-1:0]       imem_data,
    output logic [cpu_pkg::xlen-1:0]       imem_addr,
    output logic                           wb_valid,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
    output logic [cpu_pkg::xlen-1:0]       wb_data
);
    import cpu_pkg::*;

    // Fetch
    logic [xlen-1:0]       if_pc;
    instr_u                if_inst;
    logic                  stall, redirect;
    logic [xlen-1:0]       redirect_pc;

    // Decode and register file
    logic [reg_addr_w-1:0] rs1, rs2;
    logic [xlen-1:0]       rs1_data, rs2_data;

    // Decode to execute
    logic [3:0]            ex_alu_op;
    logic                  ex_use_imm, ex_mem_read, ex_mem_write;
    logic                  ex_branch, ex_branch_ne, ex_reg_write;
    logic [xlen-1:0]       ex_pc, ex_imm, ex_rs1_data, ex_rs2_data;
    logic [reg_addr_w-1:0] ex_rs1, ex_rs2, ex_rd;

    // Execute to memory
    logic [xlen-1:0]       mem_alu_result, mem_store_data;
    logic [reg_addr_w-1:0] mem_rd;
    logic                  mem_mem_read, mem_mem_write, mem_reg_write;

    logic                  wb_reg_write;

    fetch_unit u_fetch (
        .clk(clk), .rst_n(rst_n), .stall(stall), .redirect(redirect),
        .redirect_pc(redirect_pc), .imem_data(imem_data),
        .imem_addr(imem_addr), .if_pc(if_pc), .if_inst(if_inst)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .if_pc(if_pc), .if_inst(if_inst),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .redirect(redirect),
        .rs1(rs1), .rs2(rs2), .stall(stall),
        .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm), .ex_mem_read(ex_mem_read),
        .ex_mem_write(ex_mem_write), .ex_branch(ex_branch), .ex_branch_ne(ex_branch_ne),
        .ex_reg_write(ex_reg_write), .ex_pc(ex_pc), .ex_imm(ex_imm),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rs1_data(ex_rs1_data),
        .ex_rs2_data(ex_rs2_data), .ex_rd(ex_rd)
    );

    reg_file u_regs (
        .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2),
        .rd(wb_rd), .wr_en(wb_reg_write), .wr_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n),
        .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm), .ex_mem_read(ex_mem_read),
        .ex_mem_write(ex_mem_write), .ex_branch(ex_branch), .ex_branch_ne(ex_branch_ne),
        .ex_reg_write(ex_reg_write), .ex_pc(ex_pc), .ex_imm(ex_imm),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rs1_data(ex_rs1_data),
        .ex_rs2_data(ex_rs2_data), .ex_rd(ex_rd),
        .wb_rd(wb_rd), .wb_reg_write(wb_reg_write), .wb_data(wb_data),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .mem_alu_result(mem_alu_result), .mem_store_data(mem_store_data),
        .mem_rd(mem_rd), .mem_mem_read(mem_mem_read),
        .mem_mem_write(mem_mem_write), .mem_reg_write(mem_reg_write)
    );

    result_stage u_result (
        .clk(clk), .rst_n(rst_n),
        .mem_alu_result(mem_alu_result), .mem_store_data(mem_store_data),
        .mem_rd(mem_rd), .mem_mem_read(mem_mem_read),
        .mem_mem_write(mem_mem_write), .mem_reg_write(mem_reg_write),
        .wb_rd(wb_rd), .wb_reg_write(wb_reg_write), .wb_data(wb_data)
    );

    // Writes to x0 are not reported
    assign wb_valid = wb_reg_write && wb_rd != '0;

endmodule

// ==== verif/cpu_prog.svh ====
localparam int op_i  = 'h13;
localparam int op_ld = 'h03;

// Program words and the writebacks they must produce in retirement order
logic [31:0] prog [$];
string       exp_name [$];
logic [31:0] exp_rd [$];
logic [31:0] exp_val [$];

// Instruction encoders taking arguments in assembly order
function automatic logic [31:0] r_op(input int f7, input int f3, input int rd,
                                     input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] i_op(input int opc, input int f3, input int rd,
                                     input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

function automatic logic [31:0] sw_op(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] b_op(input int f3, input int rs1, input int rs2,
                                     input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
endfunction

task automatic expect_wb(input string name, input logic [31:0] rd, input logic [31:0] val);
    exp_name.push_back(name);
    exp_rd.push_back(rd);
    exp_val.push_back(val);
endtask

task automatic load_tables();
    prog.push_back(i_op(op_i, 0, 1, 0, 5));         // addi x1, x0, 5
    prog.push_back(i_op(op_i, 0, 2, 0, -3));        // addi x2, x0, -3
    prog.push_back(r_op(0, 0, 3, 1, 2));            // add  x3, x1, x2
    prog.push_back(r_op(32, 0, 4, 2, 1));           // sub  x4, x2, x1
    prog.push_back(r_op(0, 2, 5, 2, 1));            // slt  x5, x2, x1
    prog.push_back(r_op(0, 2, 6, 4, 2));            // slt  x6, x4, x2
    prog.push_back(i_op(op_i, 2, 7, 2, -4));        // slti x7, x2, -4
    prog.push_back(r_op(0, 1, 8, 1, 3));            // sll  x8, x1, x3
    prog.push_back(r_op(0, 5, 9, 2, 1));            // srl  x9, x2, x1
    prog.push_back(r_op(0, 4, 10, 2, 1));           // xor  x10, x2, x1
    prog.push_back(r_op(0, 6, 11, 1, 3));           // or   x11, x1, x3
    prog.push_back(i_op(op_i, 7, 12, 2, 'hf0));     // andi x12, x2, 0xf0
    prog.push_back(i_op(op_i, 6, 13, 1, 'h100));    // ori  x13, x1, 0x100
    prog.push_back(i_op(op_i, 4, 14, 1, -1));       // xori x14, x1, -1
    prog.push_back(r_op(0, 7, 15, 14, 13));         // and  x15, x14, x13
    prog.push_back(sw_op(14, 0, 8));                // sw   x14, 8(x0)
    prog.push_back(i_op(op_ld, 2, 16, 0, 8));       // lw   x16, 8(x0)
    prog.push_back(r_op(0, 0, 17, 16, 1));          // add  x17, x16, x1
    prog.push_back(sw_op(17, 0, 16));               // sw   x17, 16(x0)
    prog.push_back(i_op(op_ld, 2, 18, 0, 16));      // lw   x18, 16(x0)
    prog.push_back(i_op(op_i, 0, 0, 18, 2));        // addi x0, x18, 2
    prog.push_back(r_op(0, 0, 19, 0, 18));          // add  x19, x0, x18
    prog.push_back(b_op(0, 1, 1, 12));              // beq  x1, x1, +12
    prog.push_back(i_op(op_i, 0, 20, 0, 1));        // squashed
    prog.push_back(i_op(op_i, 0, 21, 0, 2));        // squashed
    prog.push_back(i_op(op_i, 0, 22, 0, 3));        // addi x22, x0, 3
    prog.push_back(b_op(1, 22, 1, 12));             // bne  x22, x1, +12
    prog.push_back(i_op(op_i, 0, 20, 0, 4));        // squashed
    prog.push_back(i_op(op_i, 0, 21, 0, 5));        // squashed
    prog.push_back(b_op(0, 22, 1, 8));              // beq  x22, x1, +8, falls through
    prog.push_back(i_op(op_i, 0, 23, 0, 6));        // addi x23, x0, 6
    prog.push_back(b_op(1, 1, 1, 8));               // bne  x1, x1, +8, falls through
    prog.push_back(i_op(op_i, 0, 24, 22, 7));       // addi x24, x22, 7

    expect_wb("addi", 1, 32'h0000_0005);
    expect_wb("addi negative", 2, 32'hffff_fffd);
    expect_wb("add forwarded", 3, 32'h0000_0002);
    expect_wb("sub", 4, 32'hffff_fff8);
    expect_wb("slt", 5, 32'h0000_0001);
    expect_wb("slt negative", 6, 32'h0000_0001);
    expect_wb("slti", 7, 32'h0000_0000);
    expect_wb("sll", 8, 32'h0000_0014);
    expect_wb("srl", 9, 32'h07ff_ffff);
    expect_wb("xor", 10, 32'hffff_fff8);
    expect_wb("or", 11, 32'h0000_0007);
    expect_wb("andi", 12, 32'h0000_00f0);
    expect_wb("ori", 13, 32'h0000_0105);
    expect_wb("xori", 14, 32'hffff_fffa);
    expect_wb("and forwarded", 15, 32'h0000_0100);
    expect_wb("lw after sw", 16, 32'hffff_fffa);
    expect_wb("load use", 17, 32'hffff_ffff);
    expect_wb("lw forwarded store", 18, 32'hffff_ffff);
    expect_wb("x0 read", 19, 32'hffff_ffff);
    expect_wb("branch targets", 22, 32'h0000_0003);
    expect_wb("beq not taken", 23, 32'h0000_0006);
    expect_wb("bne not taken", 24, 32'h0000_000a);
endtask

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

    localparam int timeout_cycles = 30;
    localparam int idle_cycles    = 20;
    localparam int drive_delay    = 2;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_data;
    logic [31:0] imem_addr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    `include "cpu_prog.svh"

    cpu_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Past the end of the program the core spins on beq x0, x0, 0
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (addr[1:0] == 2'b00 && idx < prog.size()) begin
            return prog[idx];
        end
        return b_op(0, 0, 0, 0);
    endfunction

    // Instruction memory answers the address of the new cycle
    initial begin
        imem_data = '0;
        forever begin
            @(posedge clk);
            #drive_delay;
            imem_data = fetch_word(imem_addr);
        end
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic wait_writeback(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #drive_delay;
            cycles++;
            if (cycles > timeout_cycles) begin
                stop_run($sformatf("Timed out waiting for the writeback of %s", name));
            end
        end while (!wb_valid);
    endtask

    // Squashed or duplicated instructions would show up here
    task automatic watch_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #drive_delay;
            if (wb_valid) begin
                stop_run($sformatf("Unexpected writeback to x%0d after the last instruction",
                                   wb_rd));
            end
        end
    endtask

    initial begin
        int idx;
        rst_n = 1'b0;
        load_tables();
        repeat (5) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        check_value("pc after reset", 32'h0000_0000, imem_addr);

        for (idx = 0; idx < exp_name.size(); idx++) begin
            wait_writeback(exp_name[idx]);
            check_value({exp_name[idx], " rd"}, exp_rd[idx], {27'd0, wb_rd});
            check_value({exp_name[idx], " data"}, exp_val[idx], wb_data);
        end

        watch_idle(idle_cycles);
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verif
rtl/cpu_pkg.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/cpu_top.sv
verif/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f project.f --top-module cpu_tb -o cpu_tb_sim
./obj_dir/cpu_tb_sim | tee sim.log

if grep -q '\*\* PASS \*\*' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
